/* logic/cache_config.svh */
// cache control config
// widths, geometry, buffer depth and register map of the cache control block

`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

`define CACHE_ADDR_W       16
`define CACHE_DATA_W       32
`define CACHE_LINES        16
`define CACHE_LINE_BYTES   16
`define CACHE_WTB_DEPTH    4
`define CACHE_CSR_ADDR_W   6
`define CACHE_VERSION      32'h0001_0200

// register map, byte offsets
`define CSR_READ_HIT       6'h00
`define CSR_READ_MISS      6'h04
`define CSR_WRITE_HIT      6'h08
`define CSR_WRITE_MISS     6'h0C
`define CSR_HIT            6'h10
`define CSR_MISS           6'h14
`define CSR_STATUS         6'h18
`define CSR_VERSION        6'h1C
`define CSR_CTRL           6'h20

`endif

/* logic/cache_ctrl_csr.sv */
// cache control registers
// AXI4-Lite slave for counters, buffer status, version and commands

`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_ctrl_csr (
   input  wire                          clk_i,
   input  wire                          arst_i,
   input  wire                          awvalid_i,
   output logic                         awready_o,
   input  cache_pkg::axil_aw_t          aw_i,
   input  wire                          wvalid_i,
   output logic                         wready_o,
   input  cache_pkg::axil_w_t           w_i,
   output logic                         bvalid_o,
   input  wire                          bready_i,
   output cache_pkg::axil_resp_t        bresp_o,
   input  wire                          arvalid_i,
   output logic                         arready_o,
   input  cache_pkg::axil_ar_t          ar_i,
   output logic                         rvalid_o,
   input  wire                          rready_i,
   output cache_pkg::axil_r_t           r_o,
   input  wire [`CACHE_DATA_W-1:0]      read_hit_i,
   input  wire [`CACHE_DATA_W-1:0]      read_miss_i,
   input  wire [`CACHE_DATA_W-1:0]      write_hit_i,
   input  wire [`CACHE_DATA_W-1:0]      write_miss_i,
   input  wire                          wtb_empty_i,
   input  wire                          wtb_full_i,
   output logic                         clear_o,
   output logic                         invalidate_o
);

   logic                          wr_xfer;
   logic                          rd_xfer;
   logic                          wr_ctrl;
   logic [`CACHE_CSR_ADDR_W-1:0]  aw_off;
   logic [`CACHE_CSR_ADDR_W-1:0]  ar_off;
   cache_pkg::axil_r_t            rd_word;

   // word aligned offsets, byte bits ignored
   assign aw_off = {aw_i.addr[`CACHE_CSR_ADDR_W-1:2], 2'b00};
   assign ar_off = {ar_i.addr[`CACHE_CSR_ADDR_W-1:2], 2'b00};

   // AW and W taken together, one response outstanding
   assign wr_xfer   = awvalid_i && wvalid_i && !bvalid_o;
   assign awready_o = wr_xfer;
   assign wready_o  = wr_xfer;
   assign rd_xfer   = arvalid_i && !rvalid_o;
   assign arready_o = rd_xfer;

   assign wr_ctrl      = wr_xfer && (aw_off == `CSR_CTRL) && w_i.strb[0];
   assign clear_o      = wr_ctrl && w_i.data[0];
   assign invalidate_o = wr_ctrl && w_i.data[1];

   always_comb begin
      rd_word.data = '0;
      rd_word.resp = cache_pkg::AXIL_OKAY;
      case (ar_off)
         `CSR_READ_HIT:   rd_word.data = read_hit_i;
         `CSR_READ_MISS:  rd_word.data = read_miss_i;
         `CSR_WRITE_HIT:  rd_word.data = write_hit_i;
         `CSR_WRITE_MISS: rd_word.data = write_miss_i;
         `CSR_HIT:        rd_word.data = read_hit_i + write_hit_i;
         `CSR_MISS:       rd_word.data = read_miss_i + write_miss_i;
         `CSR_STATUS:     rd_word.data = {{(`CACHE_DATA_W-2){1'b0}}, wtb_full_i, wtb_empty_i};
         `CSR_VERSION:    rd_word.data = `CACHE_VERSION;
         `CSR_CTRL:       rd_word.data = '0;  // command only, reads zero
         default:         rd_word.resp = cache_pkg::AXIL_SLVERR;
      endcase
   end

   // write response
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         bvalid_o <= 1'b0;
         bresp_o  <= cache_pkg::AXIL_OKAY;
      end else if (wr_xfer) begin
         bvalid_o <= 1'b1;
         bresp_o  <= (aw_off == `CSR_CTRL) ? cache_pkg::AXIL_OKAY : cache_pkg::AXIL_SLVERR;
      end else if (bready_i) begin
         bvalid_o <= 1'b0;
      end
   end

   // read response, sampled at AR acceptance
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         rvalid_o <= 1'b0;
         r_o      <= '0;
      end else if (rd_xfer) begin
         rvalid_o <= 1'b1;
         r_o      <= rd_word;
      end else if (rready_i) begin
         rvalid_o <= 1'b0;
      end
   end

   a_r_stable: assert property (@(posedge clk_i) disable iff (arst_i)
      rvalid_o && !rready_i |=> rvalid_o && $stable(r_o));

endmodule

`default_nettype wire

/* logic/cache_event_cnt.sv */
// cache event counters
// read/write hit/miss counts, cleared by command

`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_event_cnt (
   input  wire                            clk_i,
   input  wire                            arst_i,
   input  cache_pkg::cache_evt_t          evt_i,
   input  wire                            clear_i,
   output logic [`CACHE_DATA_W-1:0]       read_hit_o,
   output logic [`CACHE_DATA_W-1:0]       read_miss_o,
   output logic [`CACHE_DATA_W-1:0]       write_hit_o,
   output logic [`CACHE_DATA_W-1:0]       write_miss_o
);

   logic [3:0]               flags;
   logic [`CACHE_DATA_W-1:0] cnt_q [4];

   assign flags = {evt_i.write_miss, evt_i.write_hit, evt_i.read_miss, evt_i.read_hit};

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         for (int i = 0; i < 4; i++) cnt_q[i] <= '0;
      end else if (clear_i) begin
         for (int i = 0; i < 4; i++) cnt_q[i] <= '0;  // clear wins over events
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (flags[i]) cnt_q[i] <= cnt_q[i] + 1'b1;  // wraps
         end
      end
   end

   assign read_hit_o   = cnt_q[0];
   assign read_miss_o  = cnt_q[1];
   assign write_hit_o  = cnt_q[2];
   assign write_miss_o = cnt_q[3];

   // directory classifies each lookup exactly once
   a_evt_onehot: assert property (@(posedge clk_i) disable iff (arst_i)
      $onehot0(flags));

endmodule

`default_nettype wire

/* logic/cache_pkg.sv */
// cache control types
// lookup request, write buffer entry, event flags and AXI4-Lite channels

`default_nettype none

`include "cache_config.svh"

package cache_pkg;

   typedef struct packed {
      logic [`CACHE_ADDR_W-1:0]   addr;   // byte address
      logic                       we;
      logic [`CACHE_DATA_W-1:0]   wdata;
      logic [`CACHE_DATA_W/8-1:0] wstrb;
   } cache_req_t;

   typedef struct packed {
      logic [`CACHE_ADDR_W-3:0]   waddr;  // word address
      logic [`CACHE_DATA_W-1:0]   data;
      logic [`CACHE_DATA_W/8-1:0] strb;
   } wtb_entry_t;

   // at most one flag per cycle
   typedef struct packed {
      logic read_hit;
      logic read_miss;
      logic write_hit;
      logic write_miss;
   } cache_evt_t;

   typedef struct packed {
      logic [`CACHE_CSR_ADDR_W-1:0] addr;
   } axil_aw_t;

   typedef struct packed {
      logic [`CACHE_CSR_ADDR_W-1:0] addr;
   } axil_ar_t;

   typedef struct packed {
      logic [`CACHE_DATA_W-1:0]   data;
      logic [`CACHE_DATA_W/8-1:0] strb;
   } axil_w_t;

   typedef enum logic [1:0] {
      AXIL_OKAY   = 2'b00,
      AXIL_SLVERR = 2'b10
   } axil_resp_t;

   typedef struct packed {
      logic [`CACHE_DATA_W-1:0] data;
      axil_resp_t               resp;
   } axil_r_t;

endpackage

`default_nettype wire

/* logic/cache_tag_dir.sv */
// cache tag directory
// direct-mapped tag and valid store, classifies lookups and pushes writes

`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_tag_dir (
   input  wire                     clk_i,
   input  wire                     arst_i,
   input  wire                     lookup_valid_i,
   input  cache_pkg::cache_req_t   lookup_i,
   output logic                    lookup_ready_o,
   output logic                    resp_valid_o,
   output logic                    resp_hit_o,
   output cache_pkg::cache_evt_t   evt_o,
   input  wire                     invalidate_i,
   input  wire                     wtb_full_i,
   output logic                    wtb_push_o,
   output cache_pkg::wtb_entry_t   wtb_entry_o
);

   localparam int OFF_W = $clog2(`CACHE_LINE_BYTES);
   localparam int IDX_W = $clog2(`CACHE_LINES);
   localparam int TAG_W = `CACHE_ADDR_W - OFF_W - IDX_W;

   logic [TAG_W-1:0]        tag_mem [`CACHE_LINES];
   logic [`CACHE_LINES-1:0] valid_q;
   logic [IDX_W-1:0]        idx;
   logic [TAG_W-1:0]        tag;
   logic                    hit;
   logic                    xfer;
   logic                    alloc;

   assign idx  = lookup_i.addr[OFF_W +: IDX_W];
   assign tag  = lookup_i.addr[`CACHE_ADDR_W-1 -: TAG_W];
   assign hit  = valid_q[idx] && (tag_mem[idx] == tag);

   // writes stall only on a full buffer
   assign lookup_ready_o = !(lookup_valid_i && lookup_i.we && wtb_full_i);
   assign xfer  = lookup_valid_i && lookup_ready_o;
   assign alloc = xfer && !lookup_i.we && !hit;  // read miss allocates

   assign wtb_push_o        = xfer && lookup_i.we;
   assign wtb_entry_o.waddr = lookup_i.addr[`CACHE_ADDR_W-1:2];
   assign wtb_entry_o.data  = lookup_i.wdata;
   assign wtb_entry_o.strb  = lookup_i.wstrb;

   always_ff @(posedge clk_i) begin
      if (alloc) tag_mem[idx] <= tag;
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         valid_q <= '0;
      end else if (invalidate_i) begin
         valid_q <= '0;  // flash clear
      end else if (alloc) begin
         valid_q[idx] <= 1'b1;
      end
   end

   // response and event one cycle after transfer
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         resp_valid_o <= 1'b0;
         resp_hit_o   <= 1'b0;
         evt_o        <= '0;
      end else begin
         resp_valid_o     <= xfer;
         resp_hit_o       <= hit;
         evt_o.read_hit   <= xfer && !lookup_i.we && hit;
         evt_o.read_miss  <= xfer && !lookup_i.we && !hit;
         evt_o.write_hit  <= xfer && lookup_i.we && hit;
         evt_o.write_miss <= xfer && lookup_i.we && !hit;
      end
   end

   a_no_push_full: assert property (@(posedge clk_i) disable iff (arst_i)
      wtb_push_o |-> !wtb_full_i);

endmodule

`default_nettype wire

/* logic/cache_top.sv */
// cache control top
// tag directory, write-through buffer, event counters and register slave

`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_top (
   input  wire                          clk_i,
   input  wire                          arst_i,
   input  wire                          lookup_valid_i,
   input  cache_pkg::cache_req_t        lookup_i,
   output logic                         lookup_ready_o,
   output logic                         resp_valid_o,
   output logic                         resp_hit_o,
   output logic                         mem_valid_o,
   output cache_pkg::wtb_entry_t        mem_o,
   input  wire                          mem_ready_i,
   input  wire                          awvalid_i,
   output logic                         awready_o,
   input  cache_pkg::axil_aw_t          aw_i,
   input  wire                          wvalid_i,
   output logic                         wready_o,
   input  cache_pkg::axil_w_t           w_i,
   output logic                         bvalid_o,
   input  wire                          bready_i,
   output cache_pkg::axil_resp_t        bresp_o,
   input  wire                          arvalid_i,
   output logic                         arready_o,
   input  cache_pkg::axil_ar_t          ar_i,
   output logic                         rvalid_o,
   input  wire                          rready_i,
   output cache_pkg::axil_r_t           r_o
);

   cache_pkg::cache_evt_t    evt;
   cache_pkg::wtb_entry_t    wtb_entry;
   logic                     wtb_push;
   logic                     wtb_full;
   logic                     wtb_empty;
   logic                     clear;
   logic                     invalidate;
   logic [`CACHE_DATA_W-1:0] read_hit_cnt;
   logic [`CACHE_DATA_W-1:0] read_miss_cnt;
   logic [`CACHE_DATA_W-1:0] write_hit_cnt;
   logic [`CACHE_DATA_W-1:0] write_miss_cnt;

   cache_tag_dir i_tag_dir (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .lookup_valid_i (lookup_valid_i),
      .lookup_i       (lookup_i),
      .lookup_ready_o (lookup_ready_o),
      .resp_valid_o   (resp_valid_o),
      .resp_hit_o     (resp_hit_o),
      .evt_o          (evt),
      .invalidate_i   (invalidate),
      .wtb_full_i     (wtb_full),
      .wtb_push_o     (wtb_push),
      .wtb_entry_o    (wtb_entry)
   );

   cache_wtbuf #(
      .DEPTH (`CACHE_WTB_DEPTH)
   ) i_wtbuf (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .push_i      (wtb_push),
      .entry_i     (wtb_entry),
      .full_o      (wtb_full),
      .empty_o     (wtb_empty),
      .mem_valid_o (mem_valid_o),
      .mem_o       (mem_o),
      .mem_ready_i (mem_ready_i)
   );

   cache_event_cnt i_event_cnt (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .evt_i        (evt),
      .clear_i      (clear),
      .read_hit_o   (read_hit_cnt),
      .read_miss_o  (read_miss_cnt),
      .write_hit_o  (write_hit_cnt),
      .write_miss_o (write_miss_cnt)
   );

   cache_ctrl_csr i_ctrl_csr (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .awvalid_i    (awvalid_i),
      .awready_o    (awready_o),
      .aw_i         (aw_i),
      .wvalid_i     (wvalid_i),
      .wready_o     (wready_o),
      .w_i          (w_i),
      .bvalid_o     (bvalid_o),
      .bready_i     (bready_i),
      .bresp_o      (bresp_o),
      .arvalid_i    (arvalid_i),
      .arready_o    (arready_o),
      .ar_i         (ar_i),
      .rvalid_o     (rvalid_o),
      .rready_i     (rready_i),
      .r_o          (r_o),
      .read_hit_i   (read_hit_cnt),
      .read_miss_i  (read_miss_cnt),
      .write_hit_i  (write_hit_cnt),
      .write_miss_i (write_miss_cnt),
      .wtb_empty_i  (wtb_empty),
      .wtb_full_i   (wtb_full),
      .clear_o      (clear),
      .invalidate_o (invalidate)
   );

endmodule

`default_nettype wire

/* logic/cache_wtbuf.sv */
// write-through buffer
// circular FIFO of write entries, head is presented on the memory port

`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_wtbuf #(
   parameter int DEPTH = `CACHE_WTB_DEPTH
) (
   input  wire                     clk_i,
   input  wire                     arst_i,
   input  wire                     push_i,
   input  cache_pkg::wtb_entry_t   entry_i,
   output logic                    full_o,
   output logic                    empty_o,
   output logic                    mem_valid_o,
   output cache_pkg::wtb_entry_t   mem_o,
   input  wire                     mem_ready_i
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   cache_pkg::wtb_entry_t mem_q [DEPTH];
   logic [PTR_W-1:0]      rd_ptr_q;
   logic [PTR_W-1:0]      wr_ptr_q;
   logic [CNT_W-1:0]      count_q;
   logic                  pop;

   assign empty_o     = (count_q == '0);
   assign full_o      = (count_q == CNT_W'(DEPTH));
   assign mem_valid_o = !empty_o;
   assign mem_o       = mem_q[rd_ptr_q];
   assign pop         = mem_valid_o && mem_ready_i;

   always_ff @(posedge clk_i) begin
      if (push_i) mem_q[wr_ptr_q] <= entry_i;
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         rd_ptr_q <= '0;
         wr_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (pop) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         // simultaneous push and pop keeps the count
         if (push_i && !pop) count_q <= count_q + 1'b1;
         else if (pop && !push_i) count_q <= count_q - 1'b1;
      end
   end

   a_mem_stable: assert property (@(posedge clk_i) disable iff (arst_i)
      mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_o));

endmodule

`default_nettype wire

/* verification/cache_tb.sv */
// cache control testbench
// directed tests of lookup classification, write-through path and registers

`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_tb;

   localparam int OFF_W          = $clog2(`CACHE_LINE_BYTES);
   localparam int IDX_W          = $clog2(`CACHE_LINES);
   localparam int TAG_W          = `CACHE_ADDR_W - OFF_W - IDX_W;
   localparam int TEST_CYCLES    = 1000;             // rough upper bound of all tests
   localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

   logic                  clk_i;
   logic                  arst_i;
   logic                  lookup_valid_i;
   cache_pkg::cache_req_t lookup_i;
   logic                  lookup_ready_o;
   logic                  resp_valid_o;
   logic                  resp_hit_o;
   logic                  mem_valid_o;
   cache_pkg::wtb_entry_t mem_o;
   logic                  mem_ready_i;
   logic                  awvalid_i;
   logic                  awready_o;
   cache_pkg::axil_aw_t   aw_i;
   logic                  wvalid_i;
   logic                  wready_o;
   cache_pkg::axil_w_t    w_i;
   logic                  bvalid_o;
   logic                  bready_i;
   cache_pkg::axil_resp_t bresp_o;
   logic                  arvalid_i;
   logic                  arready_o;
   cache_pkg::axil_ar_t   ar_i;
   logic                  rvalid_o;
   logic                  rready_i;
   cache_pkg::axil_r_t    r_o;

   // reference model of the directory, counters and buffer
   logic [TAG_W-1:0]         model_tag [`CACHE_LINES];
   logic [`CACHE_LINES-1:0]  model_valid;
   logic [`CACHE_DATA_W-1:0] m_rh;
   logic [`CACHE_DATA_W-1:0] m_rm;
   logic [`CACHE_DATA_W-1:0] m_wh;
   logic [`CACHE_DATA_W-1:0] m_wm;
   cache_pkg::wtb_entry_t    exp_q [$];

   int          errors;
   int          tests_run;
   int          tests_failed;
   int          cycle_cnt;
   int unsigned seed;

   cache_top i_dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk_i);
         cycle_cnt++;
      end
      $display("timeout after %0d cycles, a handshake never completed", cycle_cnt);
      $display("Errors found");
      $finish;
   end

   task automatic check_word(input string name, input logic [`CACHE_DATA_W-1:0] got,
                             input logic [`CACHE_DATA_W-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_resp(input string name, input cache_pkg::axil_resp_t got,
                             input cache_pkg::axil_resp_t exp);
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_hit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_mem(input string name, input cache_pkg::wtb_entry_t got,
                            input cache_pkg::wtb_entry_t exp);
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   // single lookup with random write data checked against the model
   task automatic lookup(input logic [`CACHE_ADDR_W-1:0] addr, input logic we,
                         output int stalls);
      logic [IDX_W-1:0]      idx;
      logic [TAG_W-1:0]      tag;
      logic                  exp_hit;
      cache_pkg::wtb_entry_t ent;
      idx    = addr[OFF_W +: IDX_W];
      tag    = addr[`CACHE_ADDR_W-1 -: TAG_W];
      stalls = 0;
      @(negedge clk_i);
      lookup_valid_i = 1'b1;
      lookup_i.addr  = addr;
      lookup_i.we    = we;
      lookup_i.wdata = $urandom;
      lookup_i.wstrb = 4'($urandom);
      @(posedge clk_i);
      while (!lookup_ready_o) begin
         stalls++;
         @(posedge clk_i);
      end
      exp_hit = model_valid[idx] && (model_tag[idx] == tag);  // state at transfer
      if (we) begin
         ent.waddr = addr[`CACHE_ADDR_W-1:2];
         ent.data  = lookup_i.wdata;
         ent.strb  = lookup_i.wstrb;
         exp_q.push_back(ent);
         if (exp_hit) m_wh++;
         else m_wm++;
      end else if (exp_hit) begin
         m_rh++;
      end else begin
         m_rm++;
         model_tag[idx]   = tag;  // read miss allocates
         model_valid[idx] = 1'b1;
      end
      @(negedge clk_i);
      lookup_valid_i = 1'b0;
      if (resp_valid_o !== 1'b1) begin
         errors++;
         $display("no lookup response in the cycle after the transfer at %0t ns", $time);
      end
      check_hit("resp_hit_o", resp_hit_o, exp_hit);
   endtask

   task automatic read_line(input logic [`CACHE_ADDR_W-1:0] addr);
      int stalls;
      lookup(addr, 1'b0, stalls);
   endtask

   task automatic write_line(input logic [`CACHE_ADDR_W-1:0] addr);
      int stalls;
      lookup(addr, 1'b1, stalls);
   endtask

   task automatic axi_write(input logic [`CACHE_CSR_ADDR_W-1:0] addr,
                            input logic [`CACHE_DATA_W-1:0] data,
                            output cache_pkg::axil_resp_t resp);
      @(negedge clk_i);
      awvalid_i  = 1'b1;
      wvalid_i   = 1'b1;
      aw_i.addr  = addr;
      w_i.data   = data;
      w_i.strb   = '1;
      @(posedge clk_i);
      while (!(awready_o && wready_o)) @(posedge clk_i);
      @(negedge clk_i);
      awvalid_i = 1'b0;
      wvalid_i  = 1'b0;
      bready_i  = 1'b1;
      while (!bvalid_o) @(negedge clk_i);
      resp = bresp_o;
      @(negedge clk_i);
      bready_i = 1'b0;
   endtask

   task automatic axi_read(input logic [`CACHE_CSR_ADDR_W-1:0] addr,
                           output logic [`CACHE_DATA_W-1:0] data,
                           output cache_pkg::axil_resp_t resp);
      @(negedge clk_i);
      arvalid_i = 1'b1;
      ar_i.addr = addr;
      @(posedge clk_i);
      while (!arready_o) @(posedge clk_i);
      @(negedge clk_i);
      arvalid_i = 1'b0;
      rready_i  = 1'b1;
      while (!rvalid_o) @(negedge clk_i);
      data = r_o.data;
      resp = r_o.resp;
      @(negedge clk_i);
      rready_i = 1'b0;
   endtask

   // takes the head entry off the memory port
   task automatic mem_pop;
      cache_pkg::wtb_entry_t exp;
      @(negedge clk_i);
      while (!mem_valid_o) @(negedge clk_i);
      if (exp_q.size() == 0) begin
         errors++;
         $display("memory port presented an entry that no write produced at %0t ns", $time);
      end else begin
         exp = exp_q.pop_front();
         check_mem("mem_o", mem_o, exp);
      end
      mem_ready_i = 1'b1;
      @(negedge clk_i);
      mem_ready_i = 1'b0;
   endtask

   task automatic read_expect(input string name, input logic [`CACHE_CSR_ADDR_W-1:0] addr,
                              input logic [`CACHE_DATA_W-1:0] exp_data,
                              input cache_pkg::axil_resp_t exp_resp);
      logic [`CACHE_DATA_W-1:0] data;
      cache_pkg::axil_resp_t    resp;
      axi_read(addr, data, resp);
      check_word(name, data, exp_data);
      check_resp({name, " resp"}, resp, exp_resp);
   endtask

   task automatic counter_readback;
      read_expect("read_hit", `CSR_READ_HIT, m_rh, cache_pkg::AXIL_OKAY);
      read_expect("read_miss", `CSR_READ_MISS, m_rm, cache_pkg::AXIL_OKAY);
      read_expect("write_hit", `CSR_WRITE_HIT, m_wh, cache_pkg::AXIL_OKAY);
      read_expect("write_miss", `CSR_WRITE_MISS, m_wm, cache_pkg::AXIL_OKAY);
      read_expect("hit", `CSR_HIT, m_rh + m_wh, cache_pkg::AXIL_OKAY);
      read_expect("miss", `CSR_MISS, m_rm + m_wm, cache_pkg::AXIL_OKAY);
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests_run++;
      if (errors == errors_before) begin
         $display("test %s passed", name);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d mismatches", name, errors - errors_before);
      end
   endtask

   task automatic reset_state;
      int e0;
      e0 = errors;
      counter_readback();
      read_expect("status", `CSR_STATUS, 32'h1, cache_pkg::AXIL_OKAY);
      read_expect("version", `CSR_VERSION, `CACHE_VERSION, cache_pkg::AXIL_OKAY);
      read_expect("unmapped", 6'h24, '0, cache_pkg::AXIL_SLVERR);
      report_test("reset_state", e0);
   endtask

   task automatic read_classify;
      int e0;
      e0 = errors;
      read_line(16'h0120);  // tag 01 index 2 misses
      read_line(16'h0124);  // same line, hit
      read_line(16'h0320);  // tag 03 index 2 evicts the line
      read_line(16'h0128);  // old tag misses again
      read_line(16'h0340);
      counter_readback();
      report_test("read_classify", e0);
   endtask

   task automatic write_through;
      int e0;
      e0 = errors;
      read_line(16'h0550);   // cached line
      write_line(16'h0554);  // write hit
      write_line(16'h0760);  // uncached line gives a write miss
      write_line(16'h0768);
      read_line(16'h0760);   // still misses
      repeat (3) mem_pop();
      counter_readback();
      report_test("write_through", e0);
   endtask

   task automatic back_pressure;
      int e0;
      int stalls;
      e0 = errors;
      for (int i = 0; i < `CACHE_WTB_DEPTH; i++) write_line(16'h0a00 + 16'(i * 4));
      fork
         lookup(16'h0b10, 1'b1, stalls);  // fifth write
         begin
            read_expect("status", `CSR_STATUS, 32'h2, cache_pkg::AXIL_OKAY);
            repeat (`CACHE_WTB_DEPTH + 1) mem_pop();
         end
      join
      if (stalls == 0) begin
         errors++;
         $display("fifth write was accepted while the write buffer was full");
      end
      if (mem_valid_o !== 1'b0) begin
         errors++;
         $display("memory port still presents an entry after all writes were drained");
      end
      read_expect("status", `CSR_STATUS, 32'h1, cache_pkg::AXIL_OKAY);
      counter_readback();
      report_test("back_pressure", e0);
   endtask

   task automatic invalidate_lines;
      int                    e0;
      cache_pkg::axil_resp_t resp;
      e0 = errors;
      read_line(16'h0c80);
      read_line(16'h0c80);  // hit
      read_line(16'h0d90);
      read_line(16'h0d90);  // hit
      axi_write(`CSR_CTRL, 32'h2, resp);
      check_resp("ctrl bresp", resp, cache_pkg::AXIL_OKAY);
      model_valid = '0;
      read_line(16'h0c80);  // both lines miss now
      read_line(16'h0d90);
      counter_readback();   // counts survive the invalidate
      report_test("invalidate", e0);
   endtask

   task automatic clear_and_errors;
      int                    e0;
      cache_pkg::axil_resp_t resp;
      e0 = errors;
      axi_write(`CSR_READ_MISS, 32'hffff_ffff, resp);
      check_resp("counter bresp", resp, cache_pkg::AXIL_SLVERR);
      counter_readback();
      axi_write(`CSR_CTRL, 32'h1, resp);
      check_resp("ctrl bresp", resp, cache_pkg::AXIL_OKAY);
      m_rh = '0;
      m_rm = '0;
      m_wh = '0;
      m_wm = '0;
      counter_readback();
      report_test("clear_and_errors", e0);
   endtask

   initial begin
      seed = 58995;
      void'($urandom(seed));
      errors         = 0;
      tests_run      = 0;
      tests_failed   = 0;
      arst_i         = 1'b1;
      lookup_valid_i = 1'b0;
      lookup_i       = '0;
      mem_ready_i    = 1'b0;
      awvalid_i      = 1'b0;
      aw_i           = '0;
      wvalid_i       = 1'b0;
      w_i            = '0;
      bready_i       = 1'b0;
      arvalid_i      = 1'b0;
      ar_i           = '0;
      rready_i       = 1'b0;
      model_valid    = '0;
      m_rh           = '0;
      m_rm           = '0;
      m_wh           = '0;
      m_wm           = '0;
      repeat (16) @(negedge clk_i);
      arst_i = 1'b0;
      reset_state();
      read_classify();
      write_through();
      back_pressure();
      invalidate_lines();
      clear_and_errors();
      $display("tests run %0d, tests failed %0d, mismatches %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/cache_pkg.sv
logic/cache_tag_dir.sv
logic/cache_wtbuf.sv
logic/cache_event_cnt.sv
logic/cache_ctrl_csr.sv
logic/cache_top.sv
verification/cache_tb.sv
